/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= lsu_tb
FILELIST ?= project.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) lsu_stimulus.txt
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* banked_dmem.sv */
`timescale 1ns/10ps

module banked_dmem #(
	parameter int NUM_THREADS = simt_cfg_pkg::NUM_THREADS,
	parameter int NUM_BANKS = simt_cfg_pkg::NUM_BANKS,
	parameter int BANK_DEPTH = simt_cfg_pkg::BANK_DEPTH
) (
	input logic clk,
	input logic rst_n,
	input logic buffer_advance,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] dmem_address,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] dmem_store_data,
	input logic [NUM_THREADS-1:0] dmem_valid,
	input mem_op_pkg::mem_read_t dmem_mem_read,
	input mem_op_pkg::mem_write_t dmem_mem_write,
	output logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] dmem_load_data,
	output logic dmem_delay
);
	import simt_cfg_pkg::*;
	import mem_op_pkg::*;

	localparam int BANK_SEL_W = idx_w(NUM_BANKS);
	localparam int ROW_SEL_W = idx_w(BANK_DEPTH);
	localparam int LANE_W = idx_w(NUM_THREADS);
	localparam int ROW_LSB = BANK_LSB + BANK_SEL_W;

	typedef logic [NUM_THREADS-1:0][DATA_W-1:0] lane_data_t;

	// byte or half pulled down to bit 0, then extended per opcode
	function automatic logic [DATA_W-1:0] load_extend(input logic [DATA_W-1:0] word,
			input logic [BYTE_W-1:0] ofs, input mem_read_t op);
		logic [DATA_W-1:0] sh;
		sh = word >> {ofs, 3'b000};
		case (op)
			LB: return {{(DATA_W-8){sh[7]}}, sh[7:0]};
			LBU: return {{(DATA_W-8){1'b0}}, sh[7:0]};
			LH: return {{(DATA_W-16){sh[15]}}, sh[15:0]};
			LHU: return {{(DATA_W-16){1'b0}}, sh[15:0]};
			default: return word;
		endcase
	endfunction

	// byte enables from size and offset, data replicated across the word
	function automatic logic [DATA_W-1:0] store_merge(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] sd, input logic [BYTE_W-1:0] ofs, input mem_write_t op);
		logic [3:0] be;
		logic [DATA_W-1:0] rep;
		logic [DATA_W-1:0] res;
		case (op)
			SB: begin
				be = 4'b0001 << ofs;
				rep = {4{sd[7:0]}};
			end
			SH: begin
				be = 4'b0011 << ofs;
				rep = {2{sd[15:0]}};
			end
			default: begin
				be = 4'b1111;
				rep = sd;
			end
		endcase
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				res[8*i +: 8] = rep[8*i +: 8];
			end
		end
		return res;
	endfunction

	// low address bits that must be zero for the access size
	function automatic logic [BYTE_W-1:0] align_mask(input mem_read_t rd, input mem_write_t wr);
		if (rd == LW || wr == SW) begin
			return 2'b11;
		end
		if (rd == LH || rd == LHU || wr == SH) begin
			return 2'b01;
		end
		return 2'b00;
	endfunction

	logic is_read;
	logic is_write;
	logic first_q;
	logic done_q;
	logic [NUM_THREADS-1:0] pending_q;
	logic [NUM_THREADS-1:0] live;
	logic [NUM_THREADS-1:0] grant;
	logic [NUM_THREADS-1:0] remaining;
	logic [NUM_THREADS-1:0][BYTE_W-1:0] lane_ofs;
	logic [NUM_THREADS-1:0][BANK_SEL_W-1:0] lane_bank;
	logic [NUM_THREADS-1:0][ROW_SEL_W-1:0] lane_row;
	logic [NUM_BANKS-1:0] bank_en;
	logic [NUM_BANKS-1:0][ROW_SEL_W-1:0] bank_row;
	logic [NUM_BANKS-1:0][LANE_W-1:0] bank_lane;
	logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
	logic [NUM_BANKS-1:0][DATA_W-1:0] bank_wdata;
	logic result_hold;
	lane_data_t result_q;
	lane_data_t result_d;

	assign is_read = dmem_mem_read != NO_MEM_READ;
	assign is_write = dmem_mem_write != NO_MEM_WRITE;

	// split each lane address into byte, bank and row
	always_comb begin
		for (int t = 0; t < NUM_THREADS; t++) begin
			lane_ofs[t] = dmem_address[t][BYTE_LSB +: BYTE_W];
			lane_bank[t] = dmem_address[t][BANK_LSB +: BANK_SEL_W];
			lane_row[t] = dmem_address[t][ROW_LSB +: ROW_SEL_W];
		end
	end

	// lanes still owed service this cycle
	// first cycle takes the fresh mask straight from the buffer
	assign live = done_q ? '0 :
		(first_q ? (dmem_valid & {NUM_THREADS{is_read | is_write}}) : pending_q);

	// per bank, lowest live lane wins the single port
	always_comb begin
		grant = '0;
		bank_en = '0;
		bank_row = '0;
		bank_lane = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				if (live[t] && int'(lane_bank[t]) == b && !bank_en[b]) begin
					bank_en[b] = 1'b1;
					grant[t] = 1'b1;
					bank_row[b] = lane_row[t];
					bank_lane[b] = LANE_W'(t);
				end
			end
		end
	end

	assign remaining = live & ~grant;
	assign dmem_delay = |remaining;

	// one single ported word array per bank
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic [DATA_W-1:0] words [BANK_DEPTH];

		assign bank_rdata[b] = words[bank_row[b]];
		assign bank_wdata[b] = store_merge(bank_rdata[b], dmem_store_data[bank_lane[b]],
			lane_ofs[bank_lane[b]], dmem_mem_write);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				for (int r = 0; r < BANK_DEPTH; r++) begin
					words[r] <= '0;
				end
			end else if (bank_en[b] && is_write) begin
				words[bank_row[b]] <= bank_wdata[b];
			end
		end
	end

	// serializer state
	// done_q blocks a finished instruction held by no_slot_mem from replaying
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_q <= 1'b0;
			done_q <= 1'b0;
			pending_q <= '0;
		end else begin
			first_q <= buffer_advance;
			pending_q <= remaining;
			if (buffer_advance) begin
				done_q <= 1'b0;
			end else if (!dmem_delay) begin
				done_q <= 1'b1;
			end
		end
	end

	// merge this cycle's loads over earlier served lanes
	always_comb begin
		result_d = result_q;
		for (int t = 0; t < NUM_THREADS; t++) begin
			if (grant[t] && is_read) begin
				result_d[t] = load_extend(bank_rdata[lane_bank[t]], lane_ofs[t], dmem_mem_read);
			end
		end
	end

	// last cycle bypasses, the register keeps it while writeback waits
	assign dmem_load_data = result_d;
	assign result_hold = ~buffer_advance & ~(|grant);

	pipe_register #(
		.payload_t(lane_data_t)
	) u_result_reg (
		.clk(clk),
		.rst_n(rst_n),
		.stall(result_hold),
		.flush(buffer_advance),
		.in(result_d),
		.out(result_q)
	);

	for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lane_chk
		// address generation upstream must hand over naturally aligned lanes
		assert property (@(posedge clk) disable iff (!rst_n)
			live[t] |-> (lane_ofs[t] & align_mask(dmem_mem_read, dmem_mem_write)) == '0)
			else $error("banked_dmem: lane %0d misaligned", t);
		// no row bits may fall above the bank depth
		assert property (@(posedge clk) disable iff (!rst_n)
			live[t] |-> (dmem_address[t] >> ROW_LSB) < BANK_DEPTH)
			else $error("banked_dmem: lane %0d row out of range", t);
	end

endmodule

/* lsu.sv */
`timescale 1ns/10ps

module lsu #(
	parameter int NUM_THREADS = simt_cfg_pkg::NUM_THREADS,
	parameter int NUM_WARPS = simt_cfg_pkg::NUM_WARPS,
	localparam int WARP_NUM_W = simt_cfg_pkg::idx_w(NUM_WARPS)
) (
	input logic clk,
	input logic rst_n,
	input logic no_slot_mem,
	input logic [NUM_THREADS-1:0] req_valid,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] req_base_address,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] req_offset,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] req_store_data,
	input mem_op_pkg::mem_read_t req_mem_read,
	input mem_op_pkg::mem_write_t req_mem_write,
	input logic [simt_cfg_pkg::REG_W-1:0] req_rd,
	input logic [WARP_NUM_W-1:0] req_warp_num,
	input mem_op_pkg::wb_sel_t req_wb,
	input logic [simt_cfg_pkg::ADDR_W-1:0] req_pc,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] dmem_load_data,
	input logic dmem_delay,
	output logic out_delay,
	output logic buffer_advance,
	output logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] dmem_address,
	output logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] dmem_store_data,
	output logic [NUM_THREADS-1:0] dmem_valid,
	output mem_op_pkg::mem_read_t dmem_mem_read,
	output mem_op_pkg::mem_write_t dmem_mem_write,
	output logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] wb_loaded_data,
	output logic [simt_cfg_pkg::REG_W-1:0] wb_rd,
	output mem_op_pkg::wb_sel_t wb_sel,
	output logic [NUM_THREADS-1:0] wb_valid,
	output logic [WARP_NUM_W-1:0] wb_warp_num,
	output logic [simt_cfg_pkg::ADDR_W-1:0] wb_pc
);
	import simt_cfg_pkg::*;
	import mem_op_pkg::*;

	// one memory instruction as it sits in the buffer
	typedef struct packed {
		logic [NUM_THREADS-1:0][ADDR_W-1:0] address;
		logic [NUM_THREADS-1:0][DATA_W-1:0] store_data;
		logic [NUM_THREADS-1:0] valid;
		mem_read_t mem_read;
		mem_write_t mem_write;
		logic [REG_W-1:0] rd;
		logic [WARP_NUM_W-1:0] warp_num;
		wb_sel_t wb;
		logic [ADDR_W-1:0] pc;
	} lsu_req_t;

	// empty buffer: no lanes, no memory op, no writeback
	localparam lsu_req_t REQ_IDLE = '{
		mem_read: NO_MEM_READ,
		mem_write: NO_MEM_WRITE,
		wb: WB_NONE,
		default: '0
	};

	logic [NUM_THREADS-1:0][ADDR_W-1:0] req_address;
	lsu_req_t req_d;
	lsu_req_t req_q;

	// memory busy or writeback port taken, either one freezes the stage
	assign out_delay = dmem_delay | no_slot_mem;
	assign buffer_advance = ~out_delay;

	// address generation, one adder per lane
	always_comb begin
		for (int t = 0; t < NUM_THREADS; t++) begin
			req_address[t] = req_base_address[t] + req_offset[t];
		end
	end

	assign req_d = '{
		address: req_address,
		store_data: req_store_data,
		valid: req_valid,
		mem_read: req_mem_read,
		mem_write: req_mem_write,
		rd: req_rd,
		warp_num: req_warp_num,
		wb: req_wb,
		pc: req_pc
	};

	// request buffer, never flushed here
	pipe_register #(
		.payload_t(lsu_req_t),
		.reset_value(REQ_IDLE)
	) u_req_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.stall(out_delay),
		.flush(1'b0),
		.in(req_d),
		.out(req_q)
	);

	// buffered fields fan out to the data memory
	assign dmem_address = req_q.address;
	assign dmem_store_data = req_q.store_data;
	assign dmem_valid = req_q.valid;
	assign dmem_mem_read = req_q.mem_read;
	assign dmem_mem_write = req_q.mem_write;

	// and to the register file side
	assign wb_loaded_data = dmem_load_data;
	assign wb_rd = req_q.rd;
	assign wb_valid = req_q.valid;
	assign wb_warp_num = req_q.warp_num;
	assign wb_pc = req_q.pc;
	// no writeback until the last conflicting lane is served
	assign wb_sel = dmem_delay ? WB_NONE : req_q.wb;

	// issue side sends loads and stores as separate instructions
	assert property (@(posedge clk) disable iff (!rst_n)
		!(req_q.mem_read != NO_MEM_READ && req_q.mem_write != NO_MEM_WRITE))
		else $error("lsu: buffered instruction is both load and store");

endmodule

/* lsu_stimulus.txt */
# rd_op wr_op mask base off0 off1 off2 off3 data0 data1 data2 data3 rd warp wb pc hold
# all hex; op 7 is none; hold is no_slot_mem cycles from service cycle 1
7 2 f 100 0 4 8 c 11111111 22222222 33333333 44444444 01 0 1 400 0
2 7 f 100 0 4 8 c 0 0 0 0 05 1 2 404 0
7 2 f 200 0 10 20 30 aaaa0001 bbbb0002 cccc0003 dddd0004 02 2 1 408 0
2 7 f 200 0 10 20 30 0 0 0 0 06 3 2 40c 0
2 7 f 100 0 10 4 14 0 0 0 0 07 0 2 410 0
7 0 f 300 0 1 2 3 00000081 0000007f 000000ff 00000002 03 1 1 414 0
7 1 f 310 0 2 4 6 00008001 00007ffe 00001234 0000fedc 04 2 1 418 0
0 7 f 300 0 1 2 3 0 0 0 0 08 3 2 41c 0
4 7 f 300 0 1 2 3 0 0 0 0 09 0 2 420 0
1 7 f 310 0 2 4 6 0 0 0 0 0a 1 2 424 0
5 7 f 310 0 2 4 6 0 0 0 0 0b 2 2 428 0
7 2 f 340 0 4 8 c 5a5a0001 5a5a0002 5a5a0003 5a5a0004 0c 3 1 42c 3
7 0 f 350 0 10 20 30 00000011 00000022 00000033 00000044 0d 0 1 430 2
2 7 f 340 0 4 8 c 0 0 0 0 0e 1 2 434 2
4 7 f 350 0 10 20 30 0 0 0 0 0f 2 2 438 6
7 2 5 380 0 4 8 c 01020304 0badf00d 05060708 0badf00d 10 3 1 43c 0
2 7 f 380 0 4 8 c 0 0 0 0 11 0 2 440 0
2 7 a 100 0 4 8 c 0 0 0 0 12 1 3 444 1
2 7 6 200 0 10 20 30 0 0 0 0 13 2 2 448 0

/* lsu_tb.sv */
`timescale 1ns/10ps

module lsu_tb;
	import simt_cfg_pkg::*;
	import mem_op_pkg::*;

	localparam int NT = NUM_THREADS;
	localparam int TIMEOUT = 50;
	localparam int MEM_BYTES = NUM_BANKS * BANK_DEPTH * 4;

	logic clk;
	logic rst_n;
	logic no_slot_mem;
	logic [NT-1:0] req_valid;
	logic [NT-1:0][ADDR_W-1:0] req_base_address;
	logic [NT-1:0][ADDR_W-1:0] req_offset;
	logic [NT-1:0][DATA_W-1:0] req_store_data;
	mem_read_t req_mem_read;
	mem_write_t req_mem_write;
	logic [REG_W-1:0] req_rd;
	logic [WARP_W-1:0] req_warp_num;
	wb_sel_t req_wb;
	logic [ADDR_W-1:0] req_pc;
	logic out_delay;
	logic [NT-1:0][DATA_W-1:0] wb_loaded_data;
	logic [REG_W-1:0] wb_rd;
	wb_sel_t wb_sel;
	logic [NT-1:0] wb_valid;
	logic [WARP_W-1:0] wb_warp_num;
	logic [ADDR_W-1:0] wb_pc;

	// flat byte image, same linear byte addressing as the banks
	logic [7:0] mem_model [MEM_BYTES];
	integer seed;
	int pass_count;
	int fail_count;
	int errors;
	bit timed_out;

	lsu_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_base_address(req_base_address),
		.req_offset(req_offset),
		.req_store_data(req_store_data),
		.req_mem_read(req_mem_read),
		.req_mem_write(req_mem_write),
		.req_rd(req_rd),
		.req_warp_num(req_warp_num),
		.req_wb(req_wb),
		.req_pc(req_pc),
		.no_slot_mem(no_slot_mem),
		.out_delay(out_delay),
		.wb_loaded_data(wb_loaded_data),
		.wb_rd(wb_rd),
		.wb_sel(wb_sel),
		.wb_valid(wb_valid),
		.wb_warp_num(wb_warp_num),
		.wb_pc(wb_pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// idle request: no lanes, no memory op
	task automatic drive_idle();
		req_valid = '0;
		req_base_address = '0;
		req_offset = '0;
		req_store_data = '0;
		req_mem_read = NO_MEM_READ;
		req_mem_write = NO_MEM_WRITE;
		req_rd = '0;
		req_warp_num = '0;
		req_wb = WB_NONE;
		req_pc = '0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// load from the byte image, extension per opcode code
	function automatic logic [31:0] model_load(input logic [31:0] a, input logic [31:0] op);
		logic [31:0] w;
		logic [31:0] idx;
		logic [31:0] sh;
		idx = a & (MEM_BYTES - 1) & ~32'h3;
		w = {mem_model[idx+3], mem_model[idx+2], mem_model[idx+1], mem_model[idx]};
		sh = w >> (8 * a[1:0]);
		case (op)
			0: return {{24{sh[7]}}, sh[7:0]};
			4: return {24'h0, sh[7:0]};
			1: return {{16{sh[15]}}, sh[15:0]};
			5: return {16'h0, sh[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic model_store(input logic [31:0] a, input logic [31:0] d,
			input logic [31:0] op);
		int nbytes;
		logic [31:0] idx;
		nbytes = (op == 0) ? 1 : ((op == 1) ? 2 : 4);
		idx = a & (MEM_BYTES - 1);
		for (int i = 0; i < nbytes; i++) begin
			mem_model[idx+i] = d[8*i +: 8];
		end
	endtask

	// one instruction from capture to counted writeback
	task automatic run_test(input logic [31:0] rop, input logic [31:0] wop,
			input logic [31:0] mask, input logic [31:0] base, input logic [31:0] off [NT],
			input logic [31:0] sd [NT], input logic [31:0] rd, input logic [31:0] warp,
			input logic [31:0] wb, input logic [31:0] pc, input logic [31:0] hold);
		logic [31:0] addr [NT];
		logic [31:0] exp_load [NT];
		int bank_cnt [NUM_BANKS];
		int exp_c;
		int k;
		int waited;
		bit active;
		bit exp_delay;
		bit done;
		exp_c = 1;
		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_cnt[b] = 0;
		end
		active = (rop != 7) || (wop != 7);
		for (int t = 0; t < NT; t++) begin
			addr[t] = base + off[t];
			exp_load[t] = model_load(addr[t], rop);
			if (mask[t] && active) begin
				bank_cnt[(addr[t] >> 2) % NUM_BANKS]++;
			end
		end
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (bank_cnt[b] > exp_c) begin
				exp_c = bank_cnt[b];
			end
		end
		// same bank lanes go lowest first, so a higher lane lands last
		for (int t = 0; t < NT; t++) begin
			if (mask[t] && wop != 7) begin
				model_store(addr[t], sd[t], wop);
			end
		end

		@(negedge clk);
		no_slot_mem = 1'b0;
		for (int t = 0; t < NT; t++) begin
			req_base_address[t] = base;
			req_offset[t] = off[t];
			// inactive lanes carry junk that must never reach memory
			req_store_data[t] = mask[t] ? sd[t] : $random(seed);
		end
		req_valid = mask[NT-1:0];
		req_mem_read = mem_read_t'(rop[2:0]);
		req_mem_write = mem_write_t'(wop[2:0]);
		req_rd = rd[REG_W-1:0];
		req_warp_num = warp[WARP_W-1:0];
		req_wb = wb_sel_t'(wb[1:0]);
		req_pc = pc;
		waited = 0;
		while (out_delay) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout waiting for request capture");
				timed_out = 1'b1;
				return;
			end
		end
		@(posedge clk);

		k = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			k++;
			if (k > TIMEOUT) begin
				$display("timeout waiting for writeback");
				timed_out = 1'b1;
				return;
			end
			if (k == 1) begin
				drive_idle();
			end
			no_slot_mem = (k <= hold);
			#1;
			exp_delay = (k < exp_c) || (k <= hold);
			if (out_delay !== exp_delay) begin
				$display("Mismatch out_delay: got %h expected %h in cycle %0d",
					out_delay, exp_delay, k);
				errors++;
			end
			if (k < exp_c && wb_sel !== WB_NONE) begin
				$display("Mismatch wb_sel: got %h expected %h in cycle %0d", wb_sel, WB_NONE, k);
				errors++;
			end
			if (k >= exp_c && !no_slot_mem) begin
				done = 1'b1;
				check_value("wb_sel", 32'(wb_sel), wb);
				check_value("wb_rd", 32'(wb_rd), rd);
				check_value("wb_warp_num", 32'(wb_warp_num), warp);
				check_value("wb_pc", wb_pc, pc);
				check_value("wb_valid", 32'(wb_valid), mask);
				for (int t = 0; t < NT; t++) begin
					if (rop != 7 && mask[t]) begin
						check_value($sformatf("wb_loaded_data[%0d]", t),
							wb_loaded_data[t], exp_load[t]);
					end
				end
			end
		end
	endtask

	initial begin
		int fd;
		int n;
		int test_num;
		string line;
		logic [31:0] rop;
		logic [31:0] wop;
		logic [31:0] mask;
		logic [31:0] base;
		logic [31:0] off [NT];
		logic [31:0] sd [NT];
		logic [31:0] rd;
		logic [31:0] warp;
		logic [31:0] wb;
		logic [31:0] pc;
		logic [31:0] hold;
		seed = 32'ha0be_b2b6;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem_model[i] = 8'h00;
		end
		rst_n = 1'b0;
		no_slot_mem = 1'b0;
		drive_idle();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// reset state
		errors = 0;
		#1;
		check_value("wb_valid", 32'(wb_valid), 32'h0);
		check_value("wb_sel", 32'(wb_sel), 32'(WB_NONE));
		check_value("out_delay", 32'(out_delay), 32'h0);
		$display("test 0 reset state: %s", (errors == 0) ? "ok" : "failed");
		if (errors == 0) pass_count++;
		else fail_count++;

		fd = $fopen("lsu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			timed_out = 1'b1;
		end
		test_num = 0;
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				rop, wop, mask, base, off[0], off[1], off[2], off[3],
				sd[0], sd[1], sd[2], sd[3], rd, warp, wb, pc, hold);
			if (n != 17) begin
				continue;
			end
			test_num++;
			errors = 0;
			run_test(rop, wop, mask, base, off, sd, rd, warp, wb, pc, hold);
			if (timed_out) begin
				errors++;
			end
			$display("test %0d rd_op %0h wr_op %0h mask %h: %s", test_num, rop, wop, mask,
				(errors == 0) ? "ok" : "failed");
			if (errors == 0) pass_count++;
			else fail_count++;
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* lsu_top.sv */
`timescale 1ns/10ps

module lsu_top #(
	parameter int NUM_THREADS = simt_cfg_pkg::NUM_THREADS,
	parameter int NUM_WARPS = simt_cfg_pkg::NUM_WARPS,
	parameter int NUM_BANKS = simt_cfg_pkg::NUM_BANKS,
	parameter int BANK_DEPTH = simt_cfg_pkg::BANK_DEPTH,
	localparam int WARP_NUM_W = simt_cfg_pkg::idx_w(NUM_WARPS)
) (
	input logic clk,
	input logic rst_n,
	input logic [NUM_THREADS-1:0] req_valid,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] req_base_address,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::ADDR_W-1:0] req_offset,
	input logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] req_store_data,
	input mem_op_pkg::mem_read_t req_mem_read,
	input mem_op_pkg::mem_write_t req_mem_write,
	input logic [simt_cfg_pkg::REG_W-1:0] req_rd,
	input logic [WARP_NUM_W-1:0] req_warp_num,
	input mem_op_pkg::wb_sel_t req_wb,
	input logic [simt_cfg_pkg::ADDR_W-1:0] req_pc,
	input logic no_slot_mem,
	output logic out_delay,
	output logic [NUM_THREADS-1:0][simt_cfg_pkg::DATA_W-1:0] wb_loaded_data,
	output logic [simt_cfg_pkg::REG_W-1:0] wb_rd,
	output mem_op_pkg::wb_sel_t wb_sel,
	output logic [NUM_THREADS-1:0] wb_valid,
	output logic [WARP_NUM_W-1:0] wb_warp_num,
	output logic [simt_cfg_pkg::ADDR_W-1:0] wb_pc
);
	import simt_cfg_pkg::*;
	import mem_op_pkg::*;

	// lsu to memory, all from the buffered instruction
	logic buffer_advance;
	logic [NUM_THREADS-1:0][ADDR_W-1:0] dmem_address;
	logic [NUM_THREADS-1:0][DATA_W-1:0] dmem_store_data;
	logic [NUM_THREADS-1:0] dmem_valid;
	mem_read_t dmem_mem_read;
	mem_write_t dmem_mem_write;
	// memory back to lsu
	logic [NUM_THREADS-1:0][DATA_W-1:0] dmem_load_data;
	logic dmem_delay;

	lsu #(
		.NUM_THREADS(NUM_THREADS),
		.NUM_WARPS(NUM_WARPS)
	) u_lsu (
		.clk(clk),
		.rst_n(rst_n),
		.no_slot_mem(no_slot_mem),
		.req_valid(req_valid),
		.req_base_address(req_base_address),
		.req_offset(req_offset),
		.req_store_data(req_store_data),
		.req_mem_read(req_mem_read),
		.req_mem_write(req_mem_write),
		.req_rd(req_rd),
		.req_warp_num(req_warp_num),
		.req_wb(req_wb),
		.req_pc(req_pc),
		.dmem_load_data(dmem_load_data),
		.dmem_delay(dmem_delay),
		.out_delay(out_delay),
		.buffer_advance(buffer_advance),
		.dmem_address(dmem_address),
		.dmem_store_data(dmem_store_data),
		.dmem_valid(dmem_valid),
		.dmem_mem_read(dmem_mem_read),
		.dmem_mem_write(dmem_mem_write),
		.wb_loaded_data(wb_loaded_data),
		.wb_rd(wb_rd),
		.wb_sel(wb_sel),
		.wb_valid(wb_valid),
		.wb_warp_num(wb_warp_num),
		.wb_pc(wb_pc)
	);

	banked_dmem #(
		.NUM_THREADS(NUM_THREADS),
		.NUM_BANKS(NUM_BANKS),
		.BANK_DEPTH(BANK_DEPTH)
	) u_banked_dmem (
		.clk(clk),
		.rst_n(rst_n),
		.buffer_advance(buffer_advance),
		.dmem_address(dmem_address),
		.dmem_store_data(dmem_store_data),
		.dmem_valid(dmem_valid),
		.dmem_mem_read(dmem_mem_read),
		.dmem_mem_write(dmem_mem_write),
		.dmem_load_data(dmem_load_data),
		.dmem_delay(dmem_delay)
	);

endmodule

/* mem_op_pkg.sv */
package mem_op_pkg;

	// load opcodes, bit 2 marks the unsigned forms
	typedef enum logic [2:0] {
		LB = 3'd0,
		LH = 3'd1,
		LW = 3'd2,
		LBU = 3'd4,
		LHU = 3'd5,
		NO_MEM_READ = 3'd7
	} mem_read_t;

	// store opcodes
	typedef enum logic [2:0] {
		SB = 3'd0,
		SH = 3'd1,
		SW = 3'd2,
		NO_MEM_WRITE = 3'd7
	} mem_write_t;

	// writeback source toward the register file
	typedef enum logic [1:0] {
		WB_NONE = 2'd0,
		WB_ALU = 2'd1,
		WB_MEM = 2'd2,
		WB_PC = 2'd3
	} wb_sel_t;

	// address layout: byte in word, then bank, then row above the bank bits
	localparam int BYTE_LSB = 0;
	localparam int BYTE_W = 2;
	localparam int BANK_LSB = BYTE_LSB + BYTE_W;

endpackage

/* pipe_register.sv */
`timescale 1ns/10ps

module pipe_register #(
	parameter type payload_t = logic,
	parameter payload_t reset_value = '0
) (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input payload_t in,
	output payload_t out
);

	// flush wins over stall
	// reset and flush land on the same idle value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out <= reset_value;
		end else if (flush) begin
			out <= reset_value;
		end else if (!stall) begin
			out <= in;
		end
	end

	// the owner of this stage must never ask for both at once
	// a flushed stage that is also stalled has no defined content
	assert property (@(posedge clk) disable iff (!rst_n) !(flush && stall))
		else $error("pipe_register: flush and stall high together");

endmodule

/* project.f */
simt_cfg_pkg.sv
mem_op_pkg.sv
pipe_register.sv
lsu.sv
banked_dmem.sv
lsu_top.sv
lsu_tb.sv

/* simt_cfg_pkg.sv */
package simt_cfg_pkg;

	// ceil log2, never below one bit
	// keeps index ports legal when a count is 1
	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	// lanes per warp
	localparam int NUM_THREADS = 4;
	// warps resident in the core
	localparam int NUM_WARPS = 4;
	// data memory banks, power of two
	localparam int NUM_BANKS = 4;
	// words per bank
	localparam int BANK_DEPTH = 64;

	// datapath widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	// destination register index
	localparam int REG_W = 5;

	// derived index widths
	localparam int WARP_W = idx_w(NUM_WARPS);
	localparam int BANK_W = idx_w(NUM_BANKS);
	localparam int ROW_W = idx_w(BANK_DEPTH);

endpackage
